//--- verilog/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// datapath width of the stack machine.
`define ALU_WIDTH 16

// width of one short argument field in the instruction.
`define ARG_WIDTH 4

`endif

//--- verilog/alu_pkg.sv
package alu_pkg;

	typedef enum logic [3:0] {
		ADD   = 4'd0,
		ADC   = 4'd1,
		SUB   = 4'd2,
		SBC   = 4'd3,
		AND   = 4'd4,
		OR    = 4'd5,
		XOR   = 4'd6,
		NOT   = 4'd7,
		SHL   = 4'd8,
		SHR   = 4'd9,
		ASR   = 4'd10,
		ROL   = 4'd11,
		ROR   = 4'd12,
		PASSB = 4'd13,
		INC   = 4'd14,
		DEC   = 4'd15
	} aluOp_e;

	// both selectors have a zero source, so the literal carries its side.
	typedef enum logic [2:0] {
		REGA  = 3'd0,
		ARGA  = 3'd1,
		ARGBA = 3'd2,
		ZEROA = 3'd3
	} aluaSrc_e;

	typedef enum logic [2:0] {
		REGB  = 3'd0,
		ARGB  = 3'd1,
		ARGB5 = 3'd2,
		ONE   = 3'd3,
		ZEROB = 3'd4
	} alubSrc_e;

	typedef enum logic [1:0] {
		RUN    = 2'd0, // all flags from the alu.
		SETC   = 2'd1,
		CLRC   = 2'd2,
		CLRALL = 2'd3
	} ccMode_e;

endpackage

//--- verilog/operandSelect.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module operandSelect (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic [`ALU_WIDTH-1:0] regA,
	input  logic [`ALU_WIDTH-1:0] regB,
	input  logic [`ARG_WIDTH-1:0] argA,
	input  logic [`ARG_WIDTH-1:0] argB,
	input  logic                  b5,
	input  alu_pkg::aluaSrc_e     aluaSrc,
	input  alu_pkg::alubSrc_e     alubSrc,
	input  alu_pkg::aluOp_e       aluOp,
	input  logic                  ccLd,
	input  alu_pkg::ccMode_e      ccMode,
	output logic [`ALU_WIDTH-1:0] opA,
	output logic [`ALU_WIDTH-1:0] opB,
	output alu_pkg::aluOp_e       opS1,
	output logic                  ccLdS1,
	output alu_pkg::ccMode_e      ccModeS1
);
	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] muxA;
	logic [`ALU_WIDTH-1:0] muxB;

	always_comb begin
		case (aluaSrc)
			REGA:    muxA = regA;
			ARGA:    muxA = `ALU_WIDTH'(argA);
			ARGBA:   muxA = `ALU_WIDTH'({argB, argA}); // argB is the high nibble.
			ZEROA:   muxA = '0;
			default: muxA = '0;
		endcase
	end

	always_comb begin
		case (alubSrc)
			REGB:    muxB = regB;
			ARGB:    muxB = `ALU_WIDTH'(argB);
			ARGB5:   muxB = `ALU_WIDTH'({b5, argB}); // 5-bit immediate.
			ONE:     muxB = `ALU_WIDTH'(1);
			ZEROB:   muxB = '0;
			default: muxB = '0;
		endcase
	end

	// operands, opcode and cc controls of one instruction move together.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			opA      <= '0;
			opB      <= '0;
			opS1     <= ADD;
			ccLdS1   <= 1'b0;
			ccModeS1 <= RUN;
		end else begin
			opA      <= muxA;
			opB      <= muxB;
			opS1     <= aluOp;
			ccLdS1   <= ccLd;
			ccModeS1 <= ccMode;
		end
	end

endmodule

//--- verilog/aluCore.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module aluCore (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic [`ALU_WIDTH-1:0] opA,
	input  logic [`ALU_WIDTH-1:0] opB,
	input  alu_pkg::aluOp_e       opS1,
	input  logic                  ccLdS1,
	input  alu_pkg::ccMode_e      ccModeS1,
	input  logic                  ccCarry,
	output logic [`ALU_WIDTH-1:0] resS2,
	output logic                  zeroS2,
	output logic                  carryS2,
	output logic                  signS2,
	output logic                  parityS2,
	output logic                  ccLdS2,
	output alu_pkg::ccMode_e      ccModeS2
);
	import alu_pkg::*;

	logic                  carryIn;
	logic [`ALU_WIDTH:0]   aExt;
	logic [`ALU_WIDTH:0]   bExt;
	logic [`ALU_WIDTH:0]   cinExt;
	logic [`ALU_WIDTH:0]   sum;
	logic [`ALU_WIDTH-1:0] resNext;
	logic                  carryNext;

	// The load still sitting in stage 2 reaches the latch at the next edge.
	// Taking its carry here lets back-to-back ADC and SBC run without a stall.
	always_comb begin
		if (ccLdS2) begin
			case (ccModeS2)
				RUN:     carryIn = carryS2;
				SETC:    carryIn = 1'b1;
				default: carryIn = 1'b0; // CLRC and CLRALL.
			endcase
		end else begin
			carryIn = ccCarry;
		end
	end

	assign aExt   = {1'b0, opA};
	assign bExt   = {1'b0, opB};
	assign cinExt = {{`ALU_WIDTH{1'b0}}, carryIn};

	always_comb begin
		sum = '0;
		case (opS1)
			ADD:     sum = aExt + bExt;
			ADC:     sum = aExt + bExt + cinExt;
			SUB:     sum = aExt - bExt; // bit 16 is the borrow.
			SBC:     sum = aExt - bExt - cinExt;
			INC:     sum = aExt + (`ALU_WIDTH+1)'(1);
			DEC:     sum = aExt - (`ALU_WIDTH+1)'(1);
			default: sum = '0;
		endcase
	end

	always_comb begin
		case (opS1)
			ADD, ADC, SUB, SBC, INC, DEC: begin
				resNext   = sum[`ALU_WIDTH-1:0];
				carryNext = sum[`ALU_WIDTH];
			end
			AND: begin
				resNext   = opA & opB;
				carryNext = 1'b0;
			end
			OR: begin
				resNext   = opA | opB;
				carryNext = 1'b0;
			end
			XOR: begin
				resNext   = opA ^ opB;
				carryNext = 1'b0;
			end
			NOT: begin
				resNext   = ~opA;
				carryNext = 1'b0;
			end
			SHL: begin
				resNext   = {opA[`ALU_WIDTH-2:0], 1'b0};
				carryNext = opA[`ALU_WIDTH-1];
			end
			SHR: begin
				resNext   = {1'b0, opA[`ALU_WIDTH-1:1]};
				carryNext = opA[0];
			end
			ASR: begin
				resNext   = {opA[`ALU_WIDTH-1], opA[`ALU_WIDTH-1:1]}; // sign kept.
				carryNext = opA[0];
			end
			ROL: begin
				resNext   = {opA[`ALU_WIDTH-2:0], opA[`ALU_WIDTH-1]};
				carryNext = opA[`ALU_WIDTH-1];
			end
			ROR: begin
				resNext   = {opA[0], opA[`ALU_WIDTH-1:1]};
				carryNext = opA[0];
			end
			PASSB: begin
				resNext   = opB;
				carryNext = 1'b0;
			end
			default: begin
				resNext   = '0;
				carryNext = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			resS2    <= '0;
			zeroS2   <= 1'b0;
			carryS2  <= 1'b0;
			signS2   <= 1'b0;
			parityS2 <= 1'b0;
			ccLdS2   <= 1'b0;
			ccModeS2 <= RUN;
		end else begin
			resS2    <= resNext;
			zeroS2   <= (resNext == '0);
			carryS2  <= carryNext;
			signS2   <= resNext[`ALU_WIDTH-1];
			parityS2 <= ^resNext; // set on an odd count of ones.
			ccLdS2   <= ccLdS1;
			ccModeS2 <= ccModeS1;
		end
	end

endmodule

//--- verilog/condCodeLatch.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module condCodeLatch (
	input  logic             CLK,
	input  logic             arstN,
	input  logic             zeroS2,
	input  logic             carryS2,
	input  logic             signS2,
	input  logic             parityS2,
	input  logic             ccLdS2,
	input  alu_pkg::ccMode_e ccModeS2,
	output logic             ccZero,
	output logic             ccCarry,
	output logic             ccSign,
	output logic             ccParity
);
	import alu_pkg::*;

	// flags only move on a load strobe.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ccZero   <= 1'b0;
			ccCarry  <= 1'b0;
			ccSign   <= 1'b0;
			ccParity <= 1'b0;
		end else if (ccLdS2) begin
			case (ccModeS2)
				RUN: begin
					ccZero   <= zeroS2;
					ccCarry  <= carryS2;
					ccSign   <= signS2;
					ccParity <= parityS2;
				end
				SETC: begin
					ccCarry <= 1'b1; // others kept.
				end
				CLRC: begin
					ccCarry <= 1'b0;
				end
				CLRALL: begin
					ccZero   <= 1'b0;
					ccCarry  <= 1'b0;
					ccSign   <= 1'b0;
					ccParity <= 1'b0;
				end
				default: begin
					ccCarry <= ccCarry;
				end
			endcase
		end
	end

endmodule

//--- verilog/fullAlu.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module fullAlu (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic [`ALU_WIDTH-1:0] regA,
	input  logic [`ALU_WIDTH-1:0] regB,
	input  alu_pkg::aluOp_e       aluOp,
	input  alu_pkg::aluaSrc_e     aluaSrc,
	input  alu_pkg::alubSrc_e     alubSrc,
	input  logic [`ARG_WIDTH-1:0] argA,
	input  logic [`ARG_WIDTH-1:0] argB,
	input  logic                  b5,
	input  logic                  ccLd,
	input  alu_pkg::ccMode_e      ccMode,
	output logic [`ALU_WIDTH-1:0] aluR,
	output logic                  ccZero,
	output logic                  ccCarry,
	output logic                  ccSign,
	output logic                  ccParity
);
	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] opA;
	logic [`ALU_WIDTH-1:0] opB;
	aluOp_e                opS1;
	logic                  ccLdS1;
	ccMode_e               ccModeS1;

	logic [`ALU_WIDTH-1:0] resS2;
	logic                  zeroS2;
	logic                  carryS2;
	logic                  signS2;
	logic                  parityS2;
	logic                  ccLdS2;
	ccMode_e               ccModeS2;

	operandSelect uOperandSelect (
		.CLK      (CLK),
		.arstN    (arstN),
		.regA     (regA),
		.regB     (regB),
		.argA     (argA),
		.argB     (argB),
		.b5       (b5),
		.aluaSrc  (aluaSrc),
		.alubSrc  (alubSrc),
		.aluOp    (aluOp),
		.ccLd     (ccLd),
		.ccMode   (ccMode),
		.opA      (opA),
		.opB      (opB),
		.opS1     (opS1),
		.ccLdS1   (ccLdS1),
		.ccModeS1 (ccModeS1)
	);

	aluCore uAluCore (
		.CLK      (CLK),
		.arstN    (arstN),
		.opA      (opA),
		.opB      (opB),
		.opS1     (opS1),
		.ccLdS1   (ccLdS1),
		.ccModeS1 (ccModeS1),
		.ccCarry  (ccCarry), // carry-in from the latch.
		.resS2    (resS2),
		.zeroS2   (zeroS2),
		.carryS2  (carryS2),
		.signS2   (signS2),
		.parityS2 (parityS2),
		.ccLdS2   (ccLdS2),
		.ccModeS2 (ccModeS2)
	);

	condCodeLatch uCondCodeLatch (
		.CLK      (CLK),
		.arstN    (arstN),
		.zeroS2   (zeroS2),
		.carryS2  (carryS2),
		.signS2   (signS2),
		.parityS2 (parityS2),
		.ccLdS2   (ccLdS2),
		.ccModeS2 (ccModeS2),
		.ccZero   (ccZero),
		.ccCarry  (ccCarry),
		.ccSign   (ccSign),
		.ccParity (ccParity)
	);

	assign aluR = resS2;

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic CLK,
	output logic arstN
);
	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 8 ns period.
	end

	initial begin
		arstN = 1'b0;
		repeat (4) @(posedge CLK);
		#1 arstN = 1'b1; // released clear of the edge.
	end

endmodule

//--- testbench/fullAlu_sva.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module fullAluSva (
	input logic                  CLK,
	input logic                  arstN,
	input logic [`ALU_WIDTH-1:0] opA,
	input logic [`ALU_WIDTH-1:0] opB,
	input alu_pkg::aluOp_e       opS1,
	input logic                  ccLdS1,
	input alu_pkg::ccMode_e      ccModeS1,
	input logic [`ALU_WIDTH-1:0] resS2,
	input logic                  zeroS2,
	input logic                  carryS2,
	input logic                  signS2,
	input logic                  parityS2,
	input logic                  ccLdS2,
	input alu_pkg::ccMode_e      ccModeS2,
	input logic                  ccZero,
	input logic                  ccCarry,
	input logic                  ccSign,
	input logic                  ccParity
);
	import alu_pkg::*;

	int failCount = 0;

	// the latch only moves on the edge after a strobed stage 2.
	flagHold: assert property (@(posedge CLK) disable iff (!arstN)
		!ccLdS2 |=> $stable({ccZero, ccCarry, ccSign, ccParity}))
		else begin
			$error("cc flags changed without a load strobe");
			failCount++;
		end

	resetClear: assert property (@(posedge CLK)
		!arstN |-> (opA == '0 && opB == '0 && opS1 == ADD && !ccLdS1 && ccModeS1 == RUN
			&& resS2 == '0 && !zeroS2 && !carryS2 && !signS2 && !parityS2
			&& !ccLdS2 && ccModeS2 == RUN
			&& {ccZero, ccCarry, ccSign, ccParity} == 4'b0))
		else begin
			$error("pipeline registers not cleared during reset");
			failCount++;
		end

	stage1Known: assert property (@(posedge CLK) disable iff (!arstN)
		!$isunknown({opS1, opB}))
		else begin
			$error("stage 1 opcode or operand B is unknown");
			failCount++;
		end

endmodule

bind fullAlu fullAluSva uSva (.*);

//--- testbench/fullAluTb.sv
`timescale 1ns/1ps
`include "alu_params.svh"

module fullAluTb;
	import alu_pkg::*;

	localparam int NumRandom = 300;
	localparam int ChainLen  = 24;
	localparam int NumOps    = NumRandom + ChainLen + 40; // directed ops stay under 40.

	typedef struct packed {
		aluOp_e                op;
		aluaSrc_e              aSrc;
		alubSrc_e              bSrc;
		logic [`ALU_WIDTH-1:0] rA;
		logic [`ALU_WIDTH-1:0] rB;
		logic [`ARG_WIDTH-1:0] aA;
		logic [`ARG_WIDTH-1:0] aB;
		logic                  b5;
		logic                  ld;
		ccMode_e               mode;
		int                    due;
	} opRec_t;

	logic                  CLK;
	logic                  genRstN;
	logic                  midRstN;
	logic                  arstN;
	logic [`ALU_WIDTH-1:0] regA;
	logic [`ALU_WIDTH-1:0] regB;
	aluOp_e                aluOp;
	aluaSrc_e              aluaSrc;
	alubSrc_e              alubSrc;
	logic [`ARG_WIDTH-1:0] argA;
	logic [`ARG_WIDTH-1:0] argB;
	logic                  b5;
	logic                  ccLd;
	ccMode_e               ccMode;
	logic [`ALU_WIDTH-1:0] aluR;
	logic                  ccZero;
	logic                  ccCarry;
	logic                  ccSign;
	logic                  ccParity;

	opRec_t     q[$];
	string      names[$];
	logic [3:0] mFlags; // model zero, carry, sign, parity.
	logic       flagsDue = 1'b0;
	string      flagsName;
	int         edgeCnt = 0;

	clockGen uClockGen (
		.CLK   (CLK),
		.arstN (genRstN)
	);

	assign arstN = genRstN & midRstN;

	fullAlu u_dut (.*);

	always @(posedge CLK) edgeCnt <= edgeCnt + 1;

	function automatic opRec_t buildOp(input aluOp_e op, input aluaSrc_e aSrc,
			input alubSrc_e bSrc, input logic [`ALU_WIDTH-1:0] rA,
			input logic [`ALU_WIDTH-1:0] rB, input logic ld, input ccMode_e mode);
		opRec_t r;
		r.op   = op;
		r.aSrc = aSrc;
		r.bSrc = bSrc;
		r.rA   = rA;
		r.rB   = rB;
		r.aA   = 4'($urandom);
		r.aB   = 4'($urandom);
		r.b5   = 1'($urandom);
		r.ld   = ld;
		r.mode = mode;
		r.due  = 0;
		return r;
	endfunction

	// result from the operand rules, raw flags packed as zero, carry, sign, parity.
	function automatic logic [`ALU_WIDTH-1:0] aluModel(input opRec_t r, input logic cin,
			output logic [3:0] raw);
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
		logic [`ALU_WIDTH-1:0] res;
		logic                  c;
		int unsigned           ua;
		int unsigned           ub;
		int unsigned           uc;
		int unsigned           wide;
		case (r.aSrc)
			REGA:    a = r.rA;
			ARGA:    a = {12'h0, r.aA};
			ARGBA:   a = {8'h0, r.aB, r.aA};
			default: a = '0;
		endcase
		case (r.bSrc)
			REGB:    b = r.rB;
			ARGB:    b = {12'h0, r.aB};
			ARGB5:   b = {11'h0, r.b5, r.aB};
			ONE:     b = 16'h0001;
			default: b = '0;
		endcase
		ua = 32'(a);
		ub = 32'(b);
		uc = 32'(cin);
		c  = 1'b0;
		wide = 0;
		case (r.op)
			ADD:     wide = ua + ub;
			ADC:     wide = ua + ub + uc;
			INC:     wide = ua + 1;
			default: wide = 0;
		endcase
		case (r.op)
			ADD, ADC, INC: begin
				res = 16'(wide);
				c   = wide[16];
			end
			SUB: begin
				res = 16'(ua - ub);
				c   = ua < ub; // borrow.
			end
			SBC: begin
				res = 16'(ua - ub - uc);
				c   = ua < ub + uc;
			end
			DEC: begin
				res = 16'(ua - 1);
				c   = ua == 0;
			end
			AND:     res = a & b;
			OR:      res = a | b;
			XOR:     res = a ^ b;
			NOT:     res = ~a;
			SHL: begin
				res = a << 1;
				c   = a[15];
			end
			SHR: begin
				res = a >> 1;
				c   = a[0];
			end
			ASR: begin
				res = $signed(a) >>> 1;
				c   = a[0];
			end
			ROL: begin
				res = (a << 1) | (a >> 15);
				c   = a[15];
			end
			ROR: begin
				res = (a >> 1) | (a << 15);
				c   = a[0];
			end
			default: res = b; // PASSB.
		endcase
		raw = {res == '0, c, res[15], ^res};
		return res;
	endfunction

	task automatic compareResult(input string name, input logic [`ALU_WIDTH-1:0] expected,
			input logic [`ALU_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected aluR %h, actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "aluR mismatch");
		end
	endtask

	task automatic compareFlags(input string name, input logic [3:0] expected,
			input logic [3:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected zcsp %b, actual %b", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "condition code mismatch");
		end
	endtask

	task automatic issueOp(input string name, input opRec_t r);
		@(posedge CLK);
		#1;
		regA    = r.rA;
		regB    = r.rB;
		aluOp   = r.op;
		aluaSrc = r.aSrc;
		alubSrc = r.bSrc;
		argA    = r.aA;
		argB    = r.aB;
		b5      = r.b5;
		ccLd    = r.ld;
		ccMode  = r.mode;
		r.due   = edgeCnt + 2; // sampled at the next edge, on aluR one edge later.
		q.push_back(r);
		names.push_back(name);
	endtask

	always @(negedge CLK) begin : checkProc
		opRec_t                cur;
		string                 name;
		logic [`ALU_WIDTH-1:0] expRes;
		logic [3:0]            raw;
		if (!arstN) begin
			q.delete(); // in-flight ops are lost.
			names.delete();
			mFlags   = 4'b0;
			flagsDue = 1'b0;
		end else begin
			// the latch trails aluR by one edge.
			if (flagsDue) begin
				compareFlags(flagsName, mFlags, {ccZero, ccCarry, ccSign, ccParity});
				flagsDue = 1'b0;
			end
			if (q.size() != 0 && q[0].due == edgeCnt) begin
				cur    = q.pop_front();
				name   = names.pop_front();
				expRes = aluModel(cur, mFlags[2], raw);
				if (cur.ld) begin
					case (cur.mode)
						RUN:     mFlags = raw;
						SETC:    mFlags[2] = 1'b1;
						CLRC:    mFlags[2] = 1'b0;
						default: mFlags = 4'b0;
					endcase
				end
				compareResult(name, expRes, aluR);
				flagsName = name;
				flagsDue  = 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(8 * (NumOps + 20));
		$display("watchdog: the run did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin : mainProc
		ccMode_e m;
		void'($urandom(32'hb4dc9d2d));
		midRstN = 1'b1;
		regA    = '0;
		regB    = '0;
		aluOp   = ADD;
		aluaSrc = REGA;
		alubSrc = REGB;
		argA    = '0;
		argB    = '0;
		b5      = 1'b0;
		ccLd    = 1'b0;
		ccMode  = RUN;
		@(posedge genRstN);

		issueOp("directedAdd", buildOp(ADD, REGA, REGB, 16'h1234, 16'h4321, 1'b1, RUN));
		issueOp("directedAdd", buildOp(ADD, REGA, REGB, 16'hffff, 16'hffff, 1'b0, RUN));
		issueOp("directedAdd", buildOp(ADD, REGA, REGB, 16'hffff, 16'hffff, 1'b1, RUN));

		for (int s = 0; s < 4; s++)
			issueOp($sformatf("srcSelectA[%0d]", s), buildOp(ADD, aluaSrc_e'(3'(s)), ZEROB,
				16'($urandom), 16'($urandom), 1'b0, RUN));
		for (int s = 0; s < 5; s++)
			issueOp($sformatf("srcSelectB[%0d]", s), buildOp(PASSB, REGA, alubSrc_e'(3'(s)),
				16'($urandom), 16'($urandom), 1'b0, RUN));

		// each one needs the carry of the op right before it.
		for (int i = 0; i < ChainLen; i++)
			issueOp($sformatf("carryChain[%0d]", i), buildOp((i % 2 == 0) ? ADC : SBC,
				REGA, REGB, 16'($urandom), 16'($urandom), 1'b1, RUN));

		for (int i = 0; i < NumRandom; i++) begin
			m = ($urandom_range(7, 0) == 0) ? ccMode_e'(2'($urandom)) : RUN;
			issueOp($sformatf("randomOps[%0d]", i), buildOp(aluOp_e'(4'($urandom)),
				aluaSrc_e'(3'($urandom_range(3, 0))), alubSrc_e'(3'($urandom_range(4, 0))),
				16'($urandom), 16'($urandom), $urandom_range(3, 0) != 0, m));
		end

		issueOp("ccModes", buildOp(ADD, REGA, REGB, 16'hffff, 16'h0001, 1'b1, RUN));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b1, CLRC));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b0, SETC));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b1, SETC));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b0, CLRALL));
		issueOp("ccModes", buildOp(ADD, REGA, REGB, 16'h8000, 16'h0000, 1'b1, RUN));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b1, SETC));
		issueOp("ccModes", buildOp(XOR, REGA, REGB, 16'h00ff, 16'h0000, 1'b1, CLRALL));

		// set carry, then reset with ops still in the pipeline.
		issueOp("midReset", buildOp(ADD, REGA, REGB, 16'hffff, 16'hffff, 1'b1, RUN));
		issueOp("midReset", buildOp(ADD, REGA, REGB, 16'h7fff, 16'h0001, 1'b1, RUN));
		issueOp("midReset", buildOp(SHL, REGA, REGB, 16'h8001, 16'h0000, 1'b1, RUN));
		@(posedge CLK);
		#5;
		ccLd    = 1'b0;
		midRstN = 1'b0;
		@(negedge CLK);
		compareResult("midReset", '0, aluR);
		compareFlags("midReset", 4'b0, {ccZero, ccCarry, ccSign, ccParity});
		@(posedge CLK);
		#3;
		midRstN = 1'b1;
		issueOp("afterReset", buildOp(ADC, REGA, REGB, 16'h0010, 16'h0001, 1'b1, RUN));
		for (int i = 0; i < 6; i++)
			issueOp($sformatf("afterReset[%0d]", i), buildOp(aluOp_e'(4'($urandom)), REGA,
				REGB, 16'($urandom), 16'($urandom), 1'b1, RUN));

		while (q.size() != 0 || flagsDue)
			@(negedge CLK);
		@(posedge CLK);
		if (u_dut.uSva.failCount != 0) begin
			$display("%0d assertion failures in the pipeline checks", u_dut.uSva.failCount);
			$display("TEST FAIL");
			$fatal(1, "assertion failures");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- Makefile
# Verilator build and run of the fullAlu testbench.
TOP := fullAluTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output.
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- files.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/operandSelect.sv
verilog/aluCore.sv
verilog/condCodeLatch.sv
verilog/fullAlu.sv
testbench/clockGen.sv
testbench/fullAlu_sva.sv
testbench/fullAluTb.sv
